// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [63:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes of the supported subset.
	typedef enum logic [6:0] {
		op_imm = 7'b0010011,
		op_reg = 7'b0110011,
		op_lui = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b // lui result.
	} alu_op_e;

	// funct3 codes, same for op and op-imm.
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// rv64 shifts take six bits of the amount.
	localparam int shamt_bits = 6;

	localparam word_t reset_pc = 64'h8000_0000;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	typedef struct packed {
		logic valid;
		isa_pkg::word_t addr;
	} ibus_req_t;

	typedef struct packed {
		logic addr_ok;
		logic data_ok;
		isa_pkg::inst_t data;
	} ibus_resp_t;

	typedef struct packed {
		logic valid;
		isa_pkg::inst_t inst;
		isa_pkg::word_t pc;
	} if_id_t;

	typedef struct packed {
		logic valid;
		isa_pkg::alu_op_e alu_op;
		isa_pkg::reg_addr_t rs1;
		isa_pkg::reg_addr_t rs2;
		isa_pkg::word_t rs1_val;
		isa_pkg::word_t rs2_val;
		isa_pkg::word_t imm;
		logic use_imm; // operand b from imm.
		isa_pkg::reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		isa_pkg::reg_addr_t rd;
		isa_pkg::word_t result;
	} ex_wb_t;

endpackage

`default_nettype wire

// File: decode/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  logic                  clk,
	input  logic                  rst,
	input  pipe_pkg::if_id_t      if_id,
	output pipe_pkg::id_ex_t      id_ex,
	input  logic                  reg_write_enable,
	input  isa_pkg::reg_addr_t    reg_dest_addr,
	input  isa_pkg::word_t        reg_write_data,
	output isa_pkg::word_t [31:0] regs
);
	import isa_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic alt;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t rs1_val;
	word_t rs2_val;
	word_t imm_i;
	word_t imm_u;

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt_bit,
			input logic is_imm);
		alu_op_e op;
		case (f3)
			f3_add: op = (alt_bit && !is_imm) ? alu_sub : alu_add; // addi has no sub.
			f3_sll: op = alu_sll;
			f3_slt: op = alu_slt;
			f3_sltu: op = alu_sltu;
			f3_xor: op = alu_xor;
			f3_srl: op = alt_bit ? alu_sra : alu_srl;
			f3_or: op = alu_or;
			f3_and: op = alu_and;
			default: op = alu_add;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(if_id.inst[6:0]);
	assign funct3 = if_id.inst[14:12];
	assign alt = if_id.inst[30]; // sub / sra select.
	assign imm_i = {{52{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_u = {{32{if_id.inst[31]}}, if_id.inst[31:12], 12'b0};

	// unused source fields read as x0.
	assign rs1 = (opcode == op_lui) ? '0 : if_id.inst[19:15];
	assign rs2 = (opcode == op_reg) ? if_id.inst[24:20] : '0;

	reg_file reg_file0 (
		.clk(clk),
		.rst(rst),
		.raddr1(rs1),
		.raddr2(rs2),
		.rdata1(rs1_val),
		.rdata2(rs2_val),
		.we(reg_write_enable),
		.waddr(reg_dest_addr),
		.wdata(reg_write_data),
		.regs(regs)
	);

	always_comb begin
		id_ex = '0;
		id_ex.rs1 = rs1;
		id_ex.rs2 = rs2;
		id_ex.rs1_val = rs1_val;
		id_ex.rs2_val = rs2_val;
		id_ex.rd = if_id.inst[11:7];
		case (opcode)
			op_imm: begin
				id_ex.valid = if_id.valid;
				id_ex.alu_op = alu_sel(funct3, alt, 1'b1);
				id_ex.imm = imm_i;
				id_ex.use_imm = 1'b1;
			end
			op_reg: begin
				id_ex.valid = if_id.valid;
				id_ex.alu_op = alu_sel(funct3, alt, 1'b0);
			end
			op_lui: begin
				id_ex.valid = if_id.valid;
				id_ex.alu_op = alu_pass_b;
				id_ex.imm = imm_u;
				id_ex.use_imm = 1'b1;
			end
			default: id_ex.valid = 1'b0; // unknown opcode is dropped.
		endcase
	end

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                  clk,
	input  logic                  rst,
	input  isa_pkg::reg_addr_t    raddr1,
	input  isa_pkg::reg_addr_t    raddr2,
	output isa_pkg::word_t        rdata1,
	output isa_pkg::word_t        rdata2,
	input  logic                  we,
	input  isa_pkg::reg_addr_t    waddr,
	input  isa_pkg::word_t        wdata,
	output isa_pkg::word_t [31:0] regs
);
	import isa_pkg::*;

	word_t [31:0] mem;
	logic wr;

	assign wr = we && (waddr != '0); // x0 never written.

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem <= '0;
		end else if (wr) begin
			mem[waddr] <= wdata;
		end
	end

	// same-cycle write is visible to the reader.
	assign rdata1 = (wr && waddr == raddr1) ? wdata : mem[raddr1];
	assign rdata2 = (wr && waddr == raddr2) ? wdata : mem[raddr2];

	assign regs = mem;

	x0_zero: assert property (@(posedge clk) mem[0] == '0)
		else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: files.f
common/isa_pkg.sv
common/pipe_pkg.sv
decode/reg_file.sv
decode/decoder.sv
hdl/fetch.sv
hdl/execute.sv
hdl/writeback.sv
hdl/riscv.sv
verification/commit_checker.sv
verification/tb_riscv.sv

// File: hdl/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  pipe_pkg::id_ex_t id_ex,
	input  pipe_pkg::ex_wb_t ex_wb,
	output pipe_pkg::ex_wb_t ex_wb_next
);
	import isa_pkg::*;

	logic fwd1;
	logic fwd2;
	word_t a;
	word_t rs2_val;
	word_t b;
	logic [shamt_bits-1:0] shamt;
	word_t result;

	// bypass from the instruction one stage ahead.
	assign fwd1 = ex_wb.valid && (ex_wb.rd != '0) && (ex_wb.rd == id_ex.rs1);
	assign fwd2 = ex_wb.valid && (ex_wb.rd != '0) && (ex_wb.rd == id_ex.rs2);

	assign a = fwd1 ? ex_wb.result : id_ex.rs1_val;
	assign rs2_val = fwd2 ? ex_wb.result : id_ex.rs2_val;
	assign b = id_ex.use_imm ? id_ex.imm : rs2_val;

	assign shamt = b[shamt_bits-1:0];

	always_comb begin
		case (id_ex.alu_op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			alu_slt: result = {63'b0, $signed(a) < $signed(b)};
			alu_sltu: result = {63'b0, a < b};
			alu_sll: result = a << shamt;
			alu_srl: result = a >> shamt;
			alu_sra: result = word_t'($signed(a) >>> shamt); // sign fill.
			alu_pass_b: result = b;
			default: result = '0;
		endcase
	end

	assign ex_wb_next = '{
		valid: id_ex.valid,
		rd: id_ex.rd,
		result: result
	};

endmodule

`default_nettype wire

// File: hdl/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch #(
	parameter isa_pkg::word_t start_pc = isa_pkg::reset_pc
) (
	input  logic                 clk,
	input  logic                 rst,
	output pipe_pkg::ibus_req_t  ireq,
	input  pipe_pkg::ibus_resp_t iresp,
	output isa_pkg::word_t       pc,
	output pipe_pkg::if_id_t     if_id,
	output logic                 awaiting
);

	logic req_on;
	logic fetched;

	// instruction returned this cycle.
	assign fetched = req_on && iresp.data_ok;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			req_on <= 1'b0;
			pc <= start_pc;
		end else begin
			req_on <= 1'b1; // first request one cycle after reset.
			if (fetched) begin
				pc <= pc + 64'd4;
			end
		end
	end

	// request stays up, next address follows data_ok directly.
	assign ireq = '{valid: req_on, addr: pc};

	assign awaiting = req_on && !iresp.data_ok;

	assign if_id = '{
		valid: fetched,
		inst: iresp.data,
		pc: pc
	};

	addr_held: assert property (
		@(posedge clk) disable iff (rst)
		ireq.valid && !iresp.data_ok |=> ireq.valid && $stable(ireq.addr)
	) else $error("fetch address changed while a request was pending");

endmodule

`default_nettype wire

// File: hdl/riscv.sv
`timescale 1ns/1ps
`default_nettype none

module riscv #(
	parameter isa_pkg::word_t start_pc = isa_pkg::reset_pc
) (
	input  logic                  clk,
	input  logic                  rst,
	output pipe_pkg::ibus_req_t   ireq,
	input  pipe_pkg::ibus_resp_t  iresp,
	output isa_pkg::word_t        pc,
	output isa_pkg::word_t [31:0] regs,
	output logic                  reg_write_enable,
	output isa_pkg::reg_addr_t    reg_dest_addr,
	output isa_pkg::word_t        reg_write_data
);
	import pipe_pkg::*;

	if_id_t if_id;
	if_id_t if_id_next;
	id_ex_t id_ex;
	id_ex_t id_ex_next;
	ex_wb_t ex_wb;
	ex_wb_t ex_wb_next;
	logic awaiting;
	logic advance;

	assign advance = !awaiting; // whole pipe freezes on a pending fetch.

	fetch #(
		.start_pc(start_pc)
	) fetch0 (
		.clk(clk),
		.rst(rst),
		.ireq(ireq),
		.iresp(iresp),
		.pc(pc),
		.if_id(if_id_next),
		.awaiting(awaiting)
	);

	decoder decoder0 (
		.clk(clk),
		.rst(rst),
		.if_id(if_id),
		.id_ex(id_ex_next),
		.reg_write_enable(reg_write_enable),
		.reg_dest_addr(reg_dest_addr),
		.reg_write_data(reg_write_data),
		.regs(regs)
	);

	execute execute0 (
		.id_ex(id_ex),
		.ex_wb(ex_wb),
		.ex_wb_next(ex_wb_next)
	);

	writeback writeback0 (
		.ex_wb(ex_wb),
		.advance(advance),
		.reg_write_enable(reg_write_enable),
		.reg_dest_addr(reg_dest_addr),
		.reg_write_data(reg_write_data)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			if_id <= '0;
			id_ex <= '0;
			ex_wb <= '0;
		end else if (advance) begin
			if_id <= if_id_next;
			id_ex <= id_ex_next;
			ex_wb <= ex_wb_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback (
	input  pipe_pkg::ex_wb_t   ex_wb,
	input  logic               advance,
	output logic               reg_write_enable,
	output isa_pkg::reg_addr_t reg_dest_addr,
	output isa_pkg::word_t     reg_write_data
);

	// one pulse per instruction, only when the pipe moves on.
	always_comb begin
		reg_write_enable = ex_wb.valid && advance && (ex_wb.rd != '0);
		reg_dest_addr = ex_wb.rd;
		reg_write_data = ex_wb.result;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the core testbench with verilator, run it and scan the log
verilator --binary --timing --assert -j 0 --top-module tb_riscv -f files.f \
	-Mdir obj_dir -o tb_riscv_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_riscv_sim > sim.log 2>&1 ; cat sim.log
grep -q "Verification failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation gave no result"; exit 1; }
exit 0

// File: verification/commit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module commit_checker #(
	parameter isa_pkg::word_t start_pc = isa_pkg::reset_pc,
	parameter int sec_len = 40
) (
	input  logic                  clk,
	input  logic                  rst,
	input  pipe_pkg::ibus_req_t   ireq,
	input  pipe_pkg::ibus_resp_t  iresp,
	input  isa_pkg::word_t        pc,
	input  isa_pkg::word_t [31:0] regs,
	input  logic                  reg_write_enable,
	input  isa_pkg::reg_addr_t    reg_dest_addr,
	input  isa_pkg::word_t        reg_write_data,
	input  int                    commits_expected,
	output logic                  done,
	output int                    errors,
	output int                    commits
);
	import isa_pkg::*;

	localparam logic [6:0] opc_imm = 7'h13;
	localparam logic [6:0] opc_reg = 7'h33;
	localparam logic [6:0] opc_lui = 7'h37;

	typedef struct {
		reg_addr_t rd;
		word_t value;
		int sec;
	} expect_t;

	string sec_names [5] = '{
		"register ops", "immediate ops", "dependency chains", "x0 handling", "random mix"
	};

	word_t model [32];
	expect_t pending [$];
	int fetched;
	int cur_sec;
	int sec_commits;
	int sec_errors;
	logic final_check;

	// architectural result of one instruction.
	function automatic word_t isa_result(input inst_t inst, input word_t s1, input word_t s2);
		word_t b;
		logic [5:0] sh;
		word_t r;
		if (inst[6:0] == opc_lui) begin
			return {{32{inst[31]}}, inst[31:12], 12'h000};
		end
		b = (inst[6:0] == opc_reg) ? s2 : {{52{inst[31]}}, inst[31:20]};
		sh = b[5:0];
		case (inst[14:12])
			3'b000: r = (inst[5] && inst[30]) ? s1 - b : s1 + b; // sub only in the register form.
			3'b001: r = s1 << sh;
			3'b010: r = {63'd0, $signed(s1) < $signed(b)};
			3'b011: r = {63'd0, s1 < b};
			3'b100: r = s1 ^ b;
			3'b101: begin
				r = s1 >> sh;
				if (inst[30] && s1[63]) begin
					r = r | ~(~64'd0 >> sh); // fill vacated top bits.
				end
			end
			3'b110: r = s1 | b;
			default: r = s1 & b;
		endcase
		return r;
	endfunction

	task automatic report_section();
		$display("section %0d (%s): %0d commits, %0d errors",
			cur_sec, sec_names[cur_sec], sec_commits, sec_errors);
		sec_commits = 0;
		sec_errors = 0;
	endtask

	task automatic record_fetch(input inst_t inst, input int idx);
		expect_t e;
		logic known;
		known = inst[6:0] == opc_imm || inst[6:0] == opc_reg || inst[6:0] == opc_lui;
		fetched++;
		if (known && inst[11:7] != 5'd0) begin
			e.rd = inst[11:7];
			e.value = isa_result(inst, model[inst[19:15]], model[inst[24:20]]);
			e.sec = idx / sec_len;
			model[e.rd] = e.value;
			pending.push_back(e);
		end
	endtask

	task automatic check_commit();
		expect_t e;
		if (pending.size() == 0) begin
			$display("commit to x%0d at %0t arrived with no instruction pending",
				reg_dest_addr, $time);
			errors++;
			sec_errors++;
		end else begin
			e = pending.pop_front();
			if (e.sec != cur_sec) begin
				report_section();
				cur_sec = e.sec;
			end
			if (reg_dest_addr !== e.rd) begin
				$display("Error at %0t: reg_dest_addr is %0d, expected %0d",
					$time, reg_dest_addr, e.rd);
				errors++;
				sec_errors++;
			end
			if (reg_write_data !== e.value) begin
				$display("Error at %0t: reg_write_data is %h, expected %h",
					$time, reg_write_data, e.value);
				errors++;
				sec_errors++;
			end
			commits++;
			sec_commits++;
			if (commits == commits_expected) begin
				report_section();
				final_check = 1'b1;
			end
		end
	endtask

	task automatic check_final_state();
		for (int r = 0; r < 32; r++) begin
			if (regs[r] !== model[r]) begin
				$display("Error at %0t: regs[%0d] is %h, expected %h",
					$time, r, regs[r], model[r]);
				errors++;
			end
		end
		if (pc !== start_pc + 64'(4 * fetched)) begin
			$display("Error at %0t: pc is %h, expected %h",
				$time, pc, start_pc + 64'(4 * fetched));
			errors++;
		end
		$display("%0d of %0d commits checked, %0d instructions fetched, %0d errors",
			commits, commits_expected, fetched, errors);
	endtask

	// sampled at the rising edge, before any stage register moves.
	always @(posedge clk) begin
		if (rst) begin
			model = '{default: '0};
			pending.delete();
			fetched = 0;
			commits = 0;
			errors = 0;
			cur_sec = 0;
			sec_commits = 0;
			sec_errors = 0;
			final_check = 1'b0;
			done <= 1'b0;
		end else if (!done) begin
			if (final_check) begin
				check_final_state(); // last write has landed by now.
				final_check = 1'b0;
				done <= 1'b1;
			end else if (ireq.valid && iresp.data_ok) begin
				record_fetch(iresp.data, int'((ireq.addr - start_pc) >> 2));
			end
			if (reg_write_enable) begin
				check_commit(); // nothing is left pending after the last commit.
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_riscv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam word_t start_pc = reset_pc;
	localparam int prog_len = 200;
	localparam int sec_len = 40;
	localparam int max_cycles = prog_len * 5 + 50;
	localparam inst_t nop = 32'h0000_0013; // addi x0, x0, 0.
	localparam logic [6:0] opc_imm = 7'h13;
	localparam logic [6:0] opc_reg = 7'h33;
	localparam logic [6:0] opc_lui = 7'h37;

	logic clk;
	logic rst;
	ibus_req_t ireq;
	ibus_resp_t iresp;
	word_t pc;
	word_t [31:0] regs;
	logic reg_write_enable;
	reg_addr_t reg_dest_addr;
	word_t reg_write_data;
	inst_t prog [prog_len];
	integer seed = 32'h8af6c50d;
	int commits_expected;
	int cycles;
	int errors;
	int commits;
	logic done;
	logic [1:0] wait_left;
	logic busy;

	riscv #(
		.start_pc(start_pc)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.ireq(ireq),
		.iresp(iresp),
		.pc(pc),
		.regs(regs),
		.reg_write_enable(reg_write_enable),
		.reg_dest_addr(reg_dest_addr),
		.reg_write_data(reg_write_data)
	);

	commit_checker #(
		.start_pc(start_pc),
		.sec_len(sec_len)
	) checker0 (
		.clk(clk),
		.rst(rst),
		.ireq(ireq),
		.iresp(iresp),
		.pc(pc),
		.regs(regs),
		.reg_write_enable(reg_write_enable),
		.reg_dest_addr(reg_dest_addr),
		.reg_write_data(reg_write_data),
		.commits_expected(commits_expected),
		.done(done),
		.errors(errors),
		.commits(commits)
	);

	function automatic reg_addr_t nz_reg();
		reg_addr_t r;
		r = 5'($random(seed));
		return (r == 5'd0) ? 5'd1 : r;
	endfunction

	function automatic inst_t lui_inst(input reg_addr_t rd);
		return {20'($random(seed)), rd, opc_lui};
	endfunction

	// random alu op, register or immediate form.
	function automatic inst_t alu_inst(input logic use_reg, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2);
		logic [2:0] f3;
		logic alt;
		logic [11:0] imm;
		f3 = 3'($random(seed));
		alt = 1'($random(seed)) && (f3 == 3'b101 || (use_reg && f3 == 3'b000));
		imm = 12'($random(seed));
		if (use_reg) begin
			return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_reg};
		end
		if (f3 == 3'b001 || f3 == 3'b101) begin
			imm = {1'b0, alt, 4'b0, imm[5:0]}; // shamt with funct6.
		end
		return {imm, rs1, f3, rd, opc_imm};
	endfunction

	task automatic build_program();
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rd;
		reg_addr_t last;
		reg_addr_t prev;
		logic [1:0] pick;
		ra = 5'd1;
		rb = 5'd16;
		last = 5'd1;
		prev = 5'd2;
		commits_expected = 0;
		for (int i = 0; i < prog_len; i++) begin
			pick = 2'($random(seed));
			case (i / sec_len)
				0: begin
					if (i % 5 == 0) begin
						ra = {1'b0, 4'($random(seed)) | 4'd1};
						rb = {1'b1, 4'($random(seed))};
					end
					case (i % 5)
						0: prog[i] = lui_inst(ra);
						1: prog[i] = {12'($random(seed)), ra, 3'b000, ra, opc_imm};
						2: prog[i] = lui_inst(rb);
						3: prog[i] = {12'($random(seed)), rb, 3'b000, rb, opc_imm};
						default: prog[i] = alu_inst(1'b1, nz_reg(), ra, rb);
					endcase
				end
				1: begin
					if (pick == 2'd3) begin
						prog[i] = lui_inst(nz_reg());
					end else begin
						prog[i] = alu_inst(1'b0, nz_reg(), 5'($random(seed)), 5'd0);
					end
				end
				2: begin
					rd = nz_reg();
					if (pick[0]) begin
						prog[i] = alu_inst(pick[1], rd, last, prev); // distance 1 on rs1.
					end else begin
						prog[i] = alu_inst(pick[1], rd, prev, last);
					end
					prev = last;
					last = rd;
				end
				3: begin
					rd = pick[1] ? 5'd0 : nz_reg();
					ra = pick[0] ? 5'd0 : 5'($random(seed));
					rb = pick[0] ? 5'($random(seed)) : 5'd0;
					prog[i] = alu_inst(1'($random(seed)), rd, ra, rb);
				end
				default: begin
					if (pick == 2'd0) begin
						prog[i] = lui_inst(5'($random(seed)));
					end else begin
						rd = 5'($random(seed));
						ra = 5'($random(seed));
						rb = 5'($random(seed));
						prog[i] = alu_inst(pick[0], rd, ra, rb);
					end
				end
			endcase
			if (prog[i][11:7] != 5'd0) begin
				commits_expected++;
			end
		end
	endtask

	function automatic inst_t fetch_word(input word_t addr);
		word_t idx;
		idx = (addr - start_pc) >> 2;
		if (idx < 64'(prog_len)) begin
			return prog[int'(idx)];
		end
		return nop; // padding past the program.
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// instruction memory, 0 to 3 wait cycles per fetch.
	always @(negedge clk) begin
		if (!ireq.valid) begin
			iresp = '0;
		end else if (wait_left == 2'd0) begin
			iresp = '{addr_ok: !busy, data_ok: 1'b1, data: fetch_word(ireq.addr)};
			busy = 1'b0;
			wait_left = 2'($random(seed));
		end else begin
			iresp = '{addr_ok: !busy, data_ok: 1'b0, data: '0};
			busy = 1'b1;
			wait_left = wait_left - 2'd1;
		end
	end

	initial begin
		rst = 1'b1;
		iresp = '0;
		busy = 1'b0;
		cycles = 0;
		wait_left = 2'($random(seed));
		build_program();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (!done && cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout after %0d cycles, only %0d of %0d expected commits seen",
				cycles, commits, commits_expected);
		end
		if (done && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
